// File: design/decode_frontend.sv
// top of the decode front end, decode stage feeding the uop queue
// dispatch reads uop_head and pops, the hazard unit drives stall_decode
`timescale 1ns/100ps

module decode_frontend
    import rv32i_types_pkg::*;
    import frontend_types_pkg::*;
(
    input  logic       CLK,
    input  logic       reset,
    input  fetch_out_t fetch_out,
    input  logic       stall_decode,
    input  logic       pop,
    output uop_t       uop_head,
    output logic       uop_valid,
    output logic       queue_full,
    output word_t      pc_decode,
    output logic       valid_decode
);

    // decode to queue
    uop_t uop_out;
    logic queue_wen;

    decode_stage i_decode_stage (
        .CLK          (CLK),
        .reset        (reset),
        .fetch_out    (fetch_out),
        .stall_decode (stall_decode),
        .queue_full   (queue_full),
        .uop_out      (uop_out),
        .queue_wen    (queue_wen),
        .pc_decode    (pc_decode),
        .valid_decode (valid_decode)
    );

    uop_queue i_uop_queue (
        .CLK       (CLK),
        .reset     (reset),
        .wen       (queue_wen),
        .wdata     (uop_out),
        .pop       (pop),
        .head      (uop_head),
        .not_empty (uop_valid),
        .full      (queue_full)
    );

endmodule

// File: design/decode_stage.sv
// decode stage: expands compressed words, runs the scalar decoder
// and builds the micro-op written into the uop queue
`timescale 1ns/100ps

module decode_stage
    import rv32i_types_pkg::*;
    import frontend_types_pkg::*;
(
    // clock and reset match the core's stage ports, nothing here is registered
    input  logic       CLK,
    input  logic       reset,
    input  fetch_out_t fetch_out,
    input  logic       stall_decode,
    input  logic       queue_full,
    output uop_t       uop_out,
    output logic       queue_wen,
    output word_t      pc_decode,
    output logic       valid_decode
);

    logic     is_compressed;
    word_t    expanded;
    logic     c_illegal;
    word_t    scalar_instr;
    control_t control;

    // anything but 2'b11 in the low bits is a 16-bit encoding
    assign is_compressed = (fetch_out.instr[1:0] != 2'b11);

    rv32c_expander i_expander (
        .c_instr   (fetch_out.instr[15:0]),
        .expanded  (expanded),
        .c_illegal (c_illegal)
    );

    assign scalar_instr = is_compressed ? expanded : fetch_out.instr;

    scalar_decode i_scalar_decode (
        .instr       (scalar_instr),
        .control_out (control)
    );

    always_comb begin
        uop_out.if_out        = fetch_out;
        uop_out.ctrl_out      = control;
        // illegal expansion is all zero, so its flags are already cleared
        uop_out.ctrl_out.illegal_insn = control.illegal_insn | (is_compressed & c_illegal);
        uop_out.is_compressed = is_compressed;
    end

    // write only a valid, unstalled bundle into a queue with room
    assign queue_wen = fetch_out.valid & ~stall_decode & ~queue_full;

    // epc bookkeeping, independent of stall
    assign pc_decode    = fetch_out.pc;
    assign valid_decode = fetch_out.valid;

endmodule

// File: design/frontend_consts.svh
// widths and queue sizing shared by the decode front end
// include wherever a width or the queue depth is needed
`ifndef FRONTEND_CONSTS_SVH
`define FRONTEND_CONSTS_SVH

// machine word, also the pc and immediate width
`define XLEN 32

// architectural register index
`define REG_IDX_W 5

// micro-op queue entries, power of two
`define UOP_QUEUE_DEPTH 4

// log2 of the queue depth
`define UOP_PTR_W 2

`endif

// File: design/frontend_types_pkg.sv
// pipeline-level bundles passed between fetch, decode and the uop queue
// builds on the instruction types
package frontend_types_pkg;

    import rv32i_types_pkg::*;

    // fetch bundle, 65 bits
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t instr;
    } fetch_out_t;

    // one queued micro-op
    typedef struct packed {
        fetch_out_t if_out;
        control_t   ctrl_out;
        // set when the fetched word was a 16-bit encoding
        logic       is_compressed;
    } uop_t;

endpackage

// File: design/rv32c_expander.sv
// combinational RV32C expander for a small subset of the compressed set
// anything outside the subset is flagged illegal and expands to zero
`timescale 1ns/100ps

module rv32c_expander
    import rv32i_types_pkg::*;
(
    input  half_t c_instr,
    output word_t expanded,
    output logic  c_illegal
);

    // full and prime register fields
    reg_idx_t   rd_full;
    reg_idx_t   rs2_full;
    reg_idx_t   prime_lo;
    reg_idx_t   prime_hi;
    // scattered immediates
    logic [11:0] ci_imm;
    logic [11:0] lsw_off;
    logic [20:0] j_off;
    logic [12:0] b_off;

    assign rd_full  = c_instr[11:7];
    assign rs2_full = c_instr[6:2];
    // primes map onto x8..x15
    assign prime_lo = {2'b01, c_instr[4:2]};
    assign prime_hi = {2'b01, c_instr[9:7]};

    // 6-bit signed immediate, sign extended to 12
    assign ci_imm  = {{6{c_instr[12]}}, c_instr[12], c_instr[6:2]};
    // word offset for c.lw / c.sw, zero extended
    assign lsw_off = {5'b0, c_instr[5], c_instr[12:10], c_instr[6], 2'b00};
    // c.j offset, imm[11|4|9:8|10|6|7|3:1|5]
    assign j_off   = {{9{c_instr[12]}}, c_instr[12], c_instr[8], c_instr[10:9],
                      c_instr[6], c_instr[7], c_instr[2], c_instr[11],
                      c_instr[5:3], 1'b0};
    // c.beqz / c.bnez offset, imm[8|4:3] and imm[7:6|2:1|5]
    assign b_off   = {{4{c_instr[12]}}, c_instr[12], c_instr[6:5], c_instr[2],
                      c_instr[11:10], c_instr[4:3], 1'b0};

    always_comb begin
        expanded  = '0;
        c_illegal = 1'b0;
        // quadrant and funct3 together
        case ({c_instr[1:0], c_instr[15:13]})
            // c.lw -> lw rd', off(rs1')
            5'b00_010: expanded = {lsw_off, prime_hi, 3'b010, prime_lo, OPC_LOAD};
            // c.sw -> sw rs2', off(rs1')
            5'b00_110: expanded = {lsw_off[11:5], prime_lo, prime_hi, 3'b010,
                                   lsw_off[4:0], OPC_STORE};
            // c.addi -> addi rd, rd, imm
            5'b01_000: expanded = {ci_imm, rd_full, 3'b000, rd_full, OPC_OP_IMM};
            // c.li -> addi rd, x0, imm
            5'b01_010: expanded = {ci_imm, 5'd0, 3'b000, rd_full, OPC_OP_IMM};
            5'b01_011: begin
                // rd == x2 is c.addi16sp, a zero immediate is reserved
                if (rd_full != 5'd2 && {c_instr[12], c_instr[6:2]} != 6'd0) begin
                    expanded = {{14{c_instr[12]}}, c_instr[12], c_instr[6:2],
                                rd_full, OPC_LUI};
                end else begin
                    c_illegal = 1'b1;
                end
            end
            // c.j -> jal x0, off
            5'b01_101: expanded = {j_off[20], j_off[10:1], j_off[11], j_off[19:12],
                                   5'd0, OPC_JAL};
            // c.beqz / c.bnez, funct3 bit 0 picks bne
            5'b01_110,
            5'b01_111: expanded = {b_off[12], b_off[10:5], 5'd0, prime_hi,
                                   2'b00, c_instr[13], b_off[4:1], b_off[11],
                                   OPC_BRANCH};
            5'b10_100: begin
                // rs2 == x0 would be jr / jalr / ebreak
                if (rs2_full != 5'd0) begin
                    // bit 12 selects c.add over c.mv
                    expanded = {7'b0, rs2_full, c_instr[12] ? rd_full : 5'd0,
                                3'b000, rd_full, OPC_OP};
                end else begin
                    c_illegal = 1'b1;
                end
            end
            // includes the all-zero word
            default: c_illegal = 1'b1;
        endcase
    end

endmodule

// File: design/rv32i_types_pkg.sv
// instruction-level types for the RV32I decoder
// words, register indices, opcodes, alu codes and the decoded control bundle
`include "frontend_consts.svh"

package rv32i_types_pkg;

    typedef logic [`XLEN-1:0]      word_t;
    typedef logic [15:0]           half_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;

    // major opcodes, bits [6:0]
    typedef logic [6:0] opcode_t;

    localparam opcode_t OPC_LUI    = 7'b0110111;
    localparam opcode_t OPC_AUIPC  = 7'b0010111;
    localparam opcode_t OPC_JAL    = 7'b1101111;
    localparam opcode_t OPC_JALR   = 7'b1100111;
    localparam opcode_t OPC_BRANCH = 7'b1100011;
    localparam opcode_t OPC_LOAD   = 7'b0000011;
    localparam opcode_t OPC_STORE  = 7'b0100011;
    localparam opcode_t OPC_OP_IMM = 7'b0010011;
    localparam opcode_t OPC_OP     = 7'b0110011;

    // alu operation codes
    typedef logic [3:0] alu_op_t;

    localparam alu_op_t ALU_ADD    = 4'd0;
    localparam alu_op_t ALU_SUB    = 4'd1;
    localparam alu_op_t ALU_SLL    = 4'd2;
    localparam alu_op_t ALU_SLT    = 4'd3;
    localparam alu_op_t ALU_SLTU   = 4'd4;
    localparam alu_op_t ALU_XOR    = 4'd5;
    localparam alu_op_t ALU_SRL    = 4'd6;
    localparam alu_op_t ALU_SRA    = 4'd7;
    localparam alu_op_t ALU_OR     = 4'd8;
    localparam alu_op_t ALU_AND    = 4'd9;
    // passes operand b through, used by lui
    localparam alu_op_t ALU_PASS_B = 4'd10;

    // decoded control, 59 bits
    typedef struct packed {
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
        alu_op_t  alu_op;
        logic     alu_src_imm;
        logic     wen;
        logic     mem_read;
        logic     mem_write;
        logic     branch;
        logic     jump;
        logic     jalr;
        logic     illegal_insn;
    } control_t;

endpackage

// File: design/scalar_decode.sv
// combinational RV32I decoder
// turns a 32-bit word into the control bundle with its sign-extended immediate
`timescale 1ns/100ps

module scalar_decode
    import rv32i_types_pkg::*;
(
    input  word_t    instr,
    output control_t control_out
);

    opcode_t    opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // immediate formats
    assign imm_i = {{20{instr[31]}}, instr[31:20]};
    assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_u = {instr[31:12], 12'b0};
    assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    // funct3 to alu code, alt picks sub / sra
    function automatic alu_op_t alu_sel(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  alu_sel = alt ? ALU_SUB : ALU_ADD;
            3'b001:  alu_sel = ALU_SLL;
            3'b010:  alu_sel = ALU_SLT;
            3'b011:  alu_sel = ALU_SLTU;
            3'b100:  alu_sel = ALU_XOR;
            3'b101:  alu_sel = alt ? ALU_SRA : ALU_SRL;
            3'b110:  alu_sel = ALU_OR;
            default: alu_sel = ALU_AND;
        endcase
    endfunction

    always_comb begin
        control_out        = '0;
        // raw register fields
        control_out.rd     = instr[11:7];
        control_out.rs1    = instr[19:15];
        control_out.rs2    = instr[24:20];
        control_out.alu_op = ALU_ADD;
        case (opcode)
            OPC_LUI: begin
                control_out.wen         = 1'b1;
                control_out.alu_src_imm = 1'b1;
                control_out.imm         = imm_u;
                control_out.alu_op      = ALU_PASS_B;
            end
            // pc + imm
            OPC_AUIPC: begin
                control_out.wen         = 1'b1;
                control_out.alu_src_imm = 1'b1;
                control_out.imm         = imm_u;
            end
            OPC_JAL: begin
                control_out.wen  = 1'b1;
                control_out.jump = 1'b1;
                control_out.imm  = imm_j;
            end
            OPC_JALR: begin
                control_out.wen          = 1'b1;
                control_out.jump         = 1'b1;
                control_out.jalr         = 1'b1;
                control_out.alu_src_imm  = 1'b1;
                control_out.imm          = imm_i;
                control_out.illegal_insn = (funct3 != 3'b000);
            end
            OPC_BRANCH: begin
                control_out.branch       = 1'b1;
                control_out.imm          = imm_b;
                // beq/bne compare by subtraction, the rest by set-less-than
                control_out.alu_op       = funct3[2] ? (funct3[1] ? ALU_SLTU : ALU_SLT)
                                                     : ALU_SUB;
                control_out.illegal_insn = (funct3[2:1] == 2'b01);
            end
            OPC_LOAD: begin
                control_out.wen          = 1'b1;
                control_out.mem_read     = 1'b1;
                control_out.alu_src_imm  = 1'b1;
                control_out.imm          = imm_i;
                // lb lh lw lbu lhu only
                control_out.illegal_insn = (funct3 == 3'b011) || (funct3[2:1] == 2'b11);
            end
            OPC_STORE: begin
                control_out.mem_write    = 1'b1;
                control_out.alu_src_imm  = 1'b1;
                control_out.imm          = imm_s;
                control_out.illegal_insn = (funct3[2] || funct3 == 3'b011);
            end
            OPC_OP_IMM: begin
                control_out.wen          = 1'b1;
                control_out.alu_src_imm  = 1'b1;
                control_out.imm          = imm_i;
                control_out.alu_op       = alu_sel(funct3, funct3 == 3'b101 && funct7[5]);
                // shift amounts leave funct7 for the shift type
                control_out.illegal_insn = (funct3 == 3'b001 && funct7 != 7'b0)
                    || (funct3 == 3'b101 && funct7 != 7'b0 && funct7 != 7'b0100000);
            end
            OPC_OP: begin
                control_out.wen          = 1'b1;
                control_out.alu_op       = alu_sel(funct3, funct7[5]);
                // alternate funct7 only for sub and sra
                control_out.illegal_insn = !(funct7 == 7'b0 || (funct7 == 7'b0100000
                    && (funct3 == 3'b000 || funct3 == 3'b101)));
            end
            default: control_out.illegal_insn = 1'b1;
        endcase
        // illegal uop must not touch state
        if (control_out.illegal_insn) begin
            control_out.wen       = 1'b0;
            control_out.mem_read  = 1'b0;
            control_out.mem_write = 1'b0;
            control_out.branch    = 1'b0;
            control_out.jump      = 1'b0;
            control_out.jalr      = 1'b0;
        end
    end

endmodule

// File: design/uop_queue.sv
// in-order circular FIFO of micro-ops between decode and dispatch
// push with wen, drain with pop, head is valid while not_empty is high
`timescale 1ns/100ps
`include "frontend_consts.svh"

module uop_queue
    import frontend_types_pkg::*;
(
    input  logic CLK,
    input  logic reset,
    input  logic wen,
    input  uop_t wdata,
    input  logic pop,
    output uop_t head,
    output logic not_empty,
    output logic full
);

    // entry storage
    uop_t                  mem [`UOP_QUEUE_DEPTH];
    logic [`UOP_PTR_W-1:0] rd_ptr;
    logic [`UOP_PTR_W-1:0] wr_ptr;
    // one extra bit to tell full from empty
    logic [`UOP_PTR_W:0]   count;
    logic                  push;
    logic                  pull;

    assign full      = (count == (`UOP_PTR_W+1)'(`UOP_QUEUE_DEPTH));
    assign not_empty = (count != '0);

    // full is taken before the pop, so push on a full queue is refused
    assign push = wen & ~full;
    // pop on an empty queue is ignored
    assign pull = pop & not_empty;

    always_ff @(posedge CLK) begin
        if (reset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pull) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // push and pop together keep the count
            case ({push, pull})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    assign head = mem[rd_ptr];

endmodule

// File: files.f
+incdir+design
design/rv32i_types_pkg.sv
design/frontend_types_pkg.sv
design/rv32c_expander.sv
design/scalar_decode.sv
design/decode_stage.sv
design/uop_queue.sv
design/decode_frontend.sv
sim/tb_decode_frontend.sv

// File: run_sim.sh
#!/bin/sh
# build and run the decode front end testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f files.f \
        --top-module tb_decode_frontend -Mdir obj_dir; then
    echo "compile failed"
    exit 1
fi

if ! ./obj_dir/Vtb_decode_frontend > sim.log 2>&1; then
    cat sim.log
    echo "simulation run failed"
    exit 1
fi

cat sim.log
if grep -q "STATUS: FAIL" sim.log; then
    exit 1
fi
if ! grep -q "STATUS: PASS" sim.log; then
    echo "no result line in sim.log"
    exit 1
fi
exit 0

// File: sim/tb_decode_frontend.sv
// self-checking testbench for the decode front end
// table of encodings pushed one by one, then stall and queue-full scenarios
`timescale 1ns/100ps

module tb_decode_frontend
    import rv32i_types_pkg::*;
    import frontend_types_pkg::*;
();

    // one table row
    // flags are {alu_src_imm, wen, mem_read, mem_write, branch, jump, jalr, illegal}
    typedef struct packed {
        word_t    instr;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    imm;
        alu_op_t  alu_op;
        logic [7:0] flags;
        logic     is_c;
    } decode_vec_t;

    logic       CLK;
    logic       reset;
    fetch_out_t fetch_out;
    logic       stall_decode;
    logic       pop;
    uop_t       uop_head;
    logic       uop_valid;
    logic       queue_full;
    word_t      pc_decode;
    logic       valid_decode;

    decode_vec_t table_q[$];
    int          errors;
    int          checks;
    integer      seed;

    decode_frontend i_dut (
        .CLK          (CLK),
        .reset        (reset),
        .fetch_out    (fetch_out),
        .stall_decode (stall_decode),
        .pop          (pop),
        .uop_head     (uop_head),
        .uop_valid    (uop_valid),
        .queue_full   (queue_full),
        .pc_decode    (pc_decode),
        .valid_decode (valid_decode)
    );

    // 100 ns period
    always #50 CLK = ~CLK;

    task automatic add_row(input word_t instr, input reg_idx_t rd, input reg_idx_t rs1,
                           input reg_idx_t rs2, input word_t imm, input alu_op_t alu_op,
                           input logic [7:0] flags, input logic is_c);
        decode_vec_t row;
        row = '{instr, rd, rs1, rs2, imm, alu_op, flags, is_c};
        table_q.push_back(row);
    endtask

    task automatic check_field(input string name, input word_t got, input word_t exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("** Error at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    // waits until uop_valid reaches the wanted level, bounded by a cycle count
    task automatic wait_uop_valid(input logic level);
        int cycles;
        cycles = 0;
        while (uop_valid !== level && cycles < 20) begin
            @(posedge CLK);
            #10;
            cycles++;
        end
        assert (uop_valid === level) else begin
            errors++;
            $display("timeout: uop_valid never became %0b at %0t", level, $time);
        end
    endtask

    // one bundle for one cycle, then idle
    task automatic push_bundle(input word_t pc, input word_t instr);
        @(posedge CLK);
        #10;
        fetch_out = '{1'b1, pc, instr};
        @(posedge CLK);
        #10;
        fetch_out.valid = 1'b0;
    endtask

    task automatic pop_once();
        pop = 1'b1;
        @(posedge CLK);
        #10;
        pop = 1'b0;
    endtask

    initial begin
        decode_vec_t row;
        word_t       instr;
        word_t       pc;
        word_t       rnd;
        CLK          = 1'b0;
        reset        = 1'b1;
        fetch_out    = '0;
        stall_decode = 1'b0;
        pop          = 1'b0;
        errors       = 0;
        checks       = 0;
        seed         = 67;

        // 32-bit encodings, one per opcode class
        add_row(32'hFFB10093, 5'd1,  5'd2,  5'd27, 32'hFFFFFFFB, ALU_ADD,    8'b11000000, 1'b0);
        add_row(32'h005201B3, 5'd3,  5'd4,  5'd5,  32'h0,        ALU_ADD,    8'b01000000, 1'b0);
        add_row(32'h40838333, 5'd6,  5'd7,  5'd8,  32'h0,        ALU_SUB,    8'b01000000, 1'b0);
        add_row(32'h12345537, 5'd10, 5'd8,  5'd3,  32'h12345000, ALU_PASS_B, 8'b11000000, 1'b0);
        add_row(32'hFFFFF297, 5'd5,  5'd31, 5'd31, 32'hFFFFF000, ALU_ADD,    8'b11000000, 1'b0);
        add_row(32'hFF9FF0EF, 5'd1,  5'd31, 5'd25, 32'hFFFFFFF8, ALU_ADD,    8'b01000100, 1'b0);
        add_row(32'h00408067, 5'd0,  5'd1,  5'd4,  32'h4,        ALU_ADD,    8'b11000110, 1'b0);
        add_row(32'hFE208EE3, 5'd29, 5'd1,  5'd2,  32'hFFFFFFFC, ALU_SUB,    8'b00001000, 1'b0);
        add_row(32'hFF042483, 5'd9,  5'd8,  5'd16, 32'hFFFFFFF0, ALU_ADD,    8'b11100000, 1'b0);
        add_row(32'h00532A23, 5'd20, 5'd6,  5'd5,  32'h14,       ALU_ADD,    8'b10010000, 1'b0);
        add_row(32'h40325213, 5'd4,  5'd4,  5'd3,  32'h403,      ALU_SRA,    8'b11000000, 1'b0);
        // illegal: unknown opcode, mul, branch funct3 010
        add_row(32'h0000007F, 5'd0,  5'd0,  5'd0,  32'h0,        ALU_ADD,    8'b00000001, 1'b0);
        add_row(32'h02208033, 5'd0,  5'd1,  5'd2,  32'h0,        ALU_ADD,    8'b00000001, 1'b0);
        add_row(32'hFE20AEE3, 5'd29, 5'd1,  5'd2,  32'hFFFFFFFC, ALU_SUB,    8'b00000001, 1'b0);
        // compressed, fields as seen after expansion
        add_row(32'h000010ED, 5'd1,  5'd1,  5'd27, 32'hFFFFFFFB, ALU_ADD,    8'b11000000, 1'b1);
        add_row(32'h0000429D, 5'd5,  5'd0,  5'd7,  32'h7,        ALU_ADD,    8'b11000000, 1'b1);
        add_row(32'h00008192, 5'd3,  5'd0,  5'd4,  32'h0,        ALU_ADD,    8'b01000000, 1'b1);
        add_row(32'h00004044, 5'd9,  5'd8,  5'd4,  32'h4,        ALU_ADD,    8'b11100000, 1'b1);
        add_row(32'h0000C404, 5'd8,  5'd8,  5'd9,  32'h8,        ALU_ADD,    8'b10010000, 1'b1);
        add_row(32'h0000BFF5, 5'd0,  5'd31, 5'd29, 32'hFFFFFFFC, ALU_ADD,    8'b01000100, 1'b1);
        add_row(32'h0000C401, 5'd8,  5'd8,  5'd0,  32'h8,        ALU_SUB,    8'b00001000, 1'b1);
        add_row(32'h00006285, 5'd5,  5'd0,  5'd0,  32'h1000,     ALU_PASS_B, 8'b11000000, 1'b1);
        // illegal compressed: all-zero word and c.addi16sp
        add_row(32'h00000000, 5'd0,  5'd0,  5'd0,  32'h0,        ALU_ADD,    8'b00000001, 1'b1);
        add_row(32'h00006105, 5'd0,  5'd0,  5'd0,  32'h0,        ALU_ADD,    8'b00000001, 1'b1);

        repeat (3) @(posedge CLK);
        #10;
        reset = 1'b0;
        check_field("uop_valid", 32'(uop_valid), 32'd0);
        check_field("queue_full", 32'(queue_full), 32'd0);

        foreach (table_q[i]) begin
            row   = table_q[i];
            rnd   = $random(seed);
            // compressed rows get random garbage in the upper half
            instr = row.is_c ? {rnd[15:0], row.instr[15:0]} : row.instr;
            pc    = 32'h8000_0000 + 32'(i) * 4;
            push_bundle(pc, instr);
            wait_uop_valid(1'b1);
            check_field("valid", 32'(uop_head.if_out.valid), 32'd1);
            check_field("pc", uop_head.if_out.pc, pc);
            check_field("instr", uop_head.if_out.instr, instr);
            check_field("rd", 32'(uop_head.ctrl_out.rd), 32'(row.rd));
            check_field("rs1", 32'(uop_head.ctrl_out.rs1), 32'(row.rs1));
            check_field("rs2", 32'(uop_head.ctrl_out.rs2), 32'(row.rs2));
            check_field("imm", uop_head.ctrl_out.imm, row.imm);
            check_field("alu_op", 32'(uop_head.ctrl_out.alu_op), 32'(row.alu_op));
            check_field("alu_src_imm", 32'(uop_head.ctrl_out.alu_src_imm), 32'(row.flags[7]));
            check_field("wen", 32'(uop_head.ctrl_out.wen), 32'(row.flags[6]));
            check_field("mem_read", 32'(uop_head.ctrl_out.mem_read), 32'(row.flags[5]));
            check_field("mem_write", 32'(uop_head.ctrl_out.mem_write), 32'(row.flags[4]));
            check_field("branch", 32'(uop_head.ctrl_out.branch), 32'(row.flags[3]));
            check_field("jump", 32'(uop_head.ctrl_out.jump), 32'(row.flags[2]));
            check_field("jalr", 32'(uop_head.ctrl_out.jalr), 32'(row.flags[1]));
            check_field("illegal_insn", 32'(uop_head.ctrl_out.illegal_insn), 32'(row.flags[0]));
            check_field("is_compressed", 32'(uop_head.is_compressed), 32'(row.is_c));
            pop_once();
            wait_uop_valid(1'b0);
        end

        // stall holds the bundle out of the queue, epc outputs still follow fetch
        @(posedge CLK);
        #10;
        stall_decode = 1'b1;
        fetch_out    = '{1'b1, 32'h0000_4440, 32'h00000013};
        #30;
        check_field("pc_decode", pc_decode, 32'h0000_4440);
        check_field("valid_decode", 32'(valid_decode), 32'd1);
        @(posedge CLK);
        #10;
        check_field("uop_valid", 32'(uop_valid), 32'd0);
        fetch_out.valid = 1'b0;
        stall_decode    = 1'b0;

        // five back-to-back bundles, the fifth meets a full queue
        for (int n = 0; n < 5; n++) begin
            @(posedge CLK);
            #10;
            fetch_out = '{1'b1, 32'h0000_1000 + 32'(n) * 4, 32'h00000013};
            // full only once four entries have gone in
            check_field("queue_full", 32'(queue_full), (n == 4) ? 32'd1 : 32'd0);
        end
        @(posedge CLK);
        #10;
        fetch_out.valid = 1'b0;
        check_field("queue_full", 32'(queue_full), 32'd1);
        for (int n = 0; n < 4; n++) begin
            wait_uop_valid(1'b1);
            check_field("pc", uop_head.if_out.pc, 32'h0000_1000 + 32'(n) * 4);
            pop_once();
        end
        check_field("uop_valid", 32'(uop_valid), 32'd0);

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule
